//--- logic/alu_pkg.sv
// ALU core shared definitions

package alu_pkg;

  // Data path width
  localparam int word_w = 8;

  // Opcode select width
  localparam int sel_w = 3;

  // Register file size and its address width
  localparam int reg_n  = 4;
  localparam int addr_w = 2;

  // Opcode values
  // NOP produces 0 and never writes back
  localparam logic [sel_w-1:0] op_nop = 3'd0;

  // Arithmetic, both wrap modulo 2**word_w
  localparam logic [sel_w-1:0] op_add = 3'd1;
  localparam logic [sel_w-1:0] op_sub = 3'd2;

  // Bitwise logic
  localparam logic [sel_w-1:0] op_and = 3'd3;
  localparam logic [sel_w-1:0] op_or  = 3'd4;

  // Logical shifts of in1 by the full value of in2
  localparam logic [sel_w-1:0] op_slt = 3'd5;
  localparam logic [sel_w-1:0] op_srt = 3'd6;

  // Inversion of in1, in2 ignored
  localparam logic [sel_w-1:0] op_not = 3'd7;

endpackage

//--- logic/alu.sv
// Eight operation ALU

module alu (
  input  logic [alu_pkg::word_w-1:0] in1,
  input  logic [alu_pkg::word_w-1:0] in2,
  input  logic [alu_pkg::sel_w-1:0]  sel,
  output logic [alu_pkg::word_w-1:0] out,
  output logic                       zero_flg
);

  // Intermediate results, one per operation group
  logic [alu_pkg::word_w-1:0] sum;
  logic [alu_pkg::word_w-1:0] diff;
  logic [alu_pkg::word_w-1:0] shl;
  logic [alu_pkg::word_w-1:0] shr;

  // Carry out is dropped so the sum wraps
  assign sum  = in1 + in2;

  // Borrow is dropped as well
  assign diff = in1 - in2;

  // Shift amount is the whole of in2, anything at or above
  // the word width clears the result
  always_comb begin
    if (in2 >= alu_pkg::word_w) begin
      shl = '0;
      shr = '0;
    end else begin
      shl = in1 << in2;
      shr = in1 >> in2;
    end
  end

  // Operation select
  always_comb begin
    case (sel)
      alu_pkg::op_nop: begin
        out = '0;
      end
      alu_pkg::op_add: begin
        out = sum;
      end
      alu_pkg::op_sub: begin
        out = diff;
      end
      alu_pkg::op_and: begin
        out = in1 & in2;
      end
      alu_pkg::op_or: begin
        out = in1 | in2;
      end
      alu_pkg::op_slt: begin
        out = shl;
      end
      alu_pkg::op_srt: begin
        out = shr;
      end
      alu_pkg::op_not: begin
        out = ~in1;
      end
      default: begin
        out = '0;
      end
    endcase
  end

  // Zero flag
  assign zero_flg = ~|out;

endmodule

//--- logic/reg_file.sv
// Four word register file

module reg_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [alu_pkg::addr_w-1:0] rs1_addr,
  input  logic [alu_pkg::addr_w-1:0] rs2_addr,
  input  logic [alu_pkg::addr_w-1:0] dbg_addr,
  output logic [alu_pkg::word_w-1:0] rs1_data,
  output logic [alu_pkg::word_w-1:0] rs2_data,
  output logic [alu_pkg::word_w-1:0] dbg_data,
  input  logic                       wb_en,
  input  logic [alu_pkg::addr_w-1:0] wb_addr,
  input  logic [alu_pkg::word_w-1:0] wb_data,
  input  logic                       load,
  input  logic [alu_pkg::addr_w-1:0] load_addr,
  input  logic [alu_pkg::word_w-1:0] load_data
);

  // Register storage
  logic [alu_pkg::word_w-1:0] regs [alu_pkg::reg_n];

  // Write side
  // Writeback wins over a load to keep the pipeline result,
  // though both at once is a protocol violation
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < alu_pkg::reg_n; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_addr] <= wb_data;
    end else if (load) begin
      regs[load_addr] <= load_data;
    end
  end

  // Operand read ports, no bypass of same edge writes
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // Debug read port
  assign dbg_data = regs[dbg_addr];

endmodule

//--- logic/alu_exec.sv
// Issue and writeback pipeline

module alu_exec (
  input  logic                       clk,
  input  logic                       reset,
  // Instruction issue
  input  logic                       issue,
  input  logic [alu_pkg::sel_w-1:0]  op,
  input  logic [alu_pkg::addr_w-1:0] rd,
  input  logic [alu_pkg::addr_w-1:0] rs1,
  input  logic [alu_pkg::addr_w-1:0] rs2,
  // Register file operands
  input  logic [alu_pkg::word_w-1:0] rs1_data,
  input  logic [alu_pkg::word_w-1:0] rs2_data,
  // ALU results
  input  logic [alu_pkg::word_w-1:0] alu_out,
  input  logic                       alu_zero,
  // ALU operands
  output logic [alu_pkg::word_w-1:0] ex_in1,
  output logic [alu_pkg::word_w-1:0] ex_in2,
  output logic [alu_pkg::sel_w-1:0]  ex_sel,
  // Register file writeback
  output logic                       wb_en,
  output logic [alu_pkg::addr_w-1:0] wb_addr,
  output logic [alu_pkg::word_w-1:0] wb_data,
  // Completion
  output logic                       done,
  output logic [alu_pkg::word_w-1:0] result,
  output logic                       zero
);

  // Execute stage
  logic                       ex_valid;
  logic [alu_pkg::sel_w-1:0]  ex_op;
  logic [alu_pkg::addr_w-1:0] ex_rd;
  logic [alu_pkg::word_w-1:0] ex_a;
  logic [alu_pkg::word_w-1:0] ex_b;

  // Operands after the forwarding muxes
  logic                       fwd_a;
  logic                       fwd_b;
  logic [alu_pkg::word_w-1:0] op_a;
  logic [alu_pkg::word_w-1:0] op_b;

  // Instruction in execute will write rd at the next edge
  assign wb_en   = ex_valid && (ex_op != alu_pkg::op_nop);
  assign wb_addr = ex_rd;
  assign wb_data = alu_out;

  // The register file still holds the old rd value this cycle,
  // so take the value straight from the ALU
  assign fwd_a = wb_en && (ex_rd == rs1);
  assign fwd_b = wb_en && (ex_rd == rs2);

  assign op_a = fwd_a ? alu_out : rs1_data;
  assign op_b = fwd_b ? alu_out : rs2_data;

  // Execute stage control
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_op    <= alu_pkg::op_nop;
    end else begin
      ex_valid <= issue;
      if (issue) begin
        ex_op <= op;
      end
    end
  end

  // Execute stage payload
  always_ff @(posedge clk) begin
    if (issue) begin
      ex_rd <= rd;
      ex_a  <= op_a;
      ex_b  <= op_b;
    end
  end

  // To the ALU
  assign ex_in1 = ex_a;
  assign ex_in2 = ex_b;
  assign ex_sel = ex_op;

  // Output registers, held between completions
  always_ff @(posedge clk) begin
    if (reset) begin
      done   <= 1'b0;
      result <= '0;
      zero   <= 1'b1;
    end else begin
      done <= ex_valid;
      if (ex_valid) begin
        result <= alu_out;
        zero   <= alu_zero;
      end
    end
  end

endmodule

//--- logic/alu_core_top.sv
// ALU core top level

module alu_core_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       issue,
  input  logic [alu_pkg::sel_w-1:0]  op,
  input  logic [alu_pkg::addr_w-1:0] rd,
  input  logic [alu_pkg::addr_w-1:0] rs1,
  input  logic [alu_pkg::addr_w-1:0] rs2,
  input  logic                       load,
  input  logic [alu_pkg::addr_w-1:0] load_addr,
  input  logic [alu_pkg::word_w-1:0] load_data,
  input  logic [alu_pkg::addr_w-1:0] dbg_addr,
  output logic [alu_pkg::word_w-1:0] dbg_data,
  output logic                       done,
  output logic [alu_pkg::word_w-1:0] result,
  output logic                       zero
);

  // Register file read data
  logic [alu_pkg::word_w-1:0] rs1_data;
  logic [alu_pkg::word_w-1:0] rs2_data;

  // Writeback path
  logic                       wb_en;
  logic [alu_pkg::addr_w-1:0] wb_addr;
  logic [alu_pkg::word_w-1:0] wb_data;

  // ALU hookup
  logic [alu_pkg::word_w-1:0] ex_in1;
  logic [alu_pkg::word_w-1:0] ex_in2;
  logic [alu_pkg::sel_w-1:0]  ex_sel;
  logic [alu_pkg::word_w-1:0] alu_out;
  logic                       alu_zero;

  reg_file i_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rs1_addr  (rs1),
    .rs2_addr  (rs2),
    .dbg_addr  (dbg_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .dbg_data  (dbg_data),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .load      (load),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  alu_exec i_alu_exec (
    .clk      (clk),
    .reset    (reset),
    .issue    (issue),
    .op       (op),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_out  (alu_out),
    .alu_zero (alu_zero),
    .ex_in1   (ex_in1),
    .ex_in2   (ex_in2),
    .ex_sel   (ex_sel),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data),
    .done     (done),
    .result   (result),
    .zero     (zero)
  );

  alu i_alu (
    .in1      (ex_in1),
    .in2      (ex_in2),
    .sel      (ex_sel),
    .out      (alu_out),
    .zero_flg (alu_zero)
  );

endmodule

//--- sim/alu_core_asserts.sv
// ALU pipeline assertions

module alu_exec_asserts (
  input logic                       clk,
  input logic                       reset,
  input logic                       issue,
  input logic [alu_pkg::sel_w-1:0]  op,
  input logic                       load,
  input logic                       wb_en,
  input logic                       done,
  input logic [alu_pkg::word_w-1:0] result,
  input logic                       zero
);
  timeunit 1ns;
  timeprecision 100ps;

  // Issue sampled, one cycle in execute, then done
  a_done_latency: assert property (
    @(posedge clk) disable iff (reset) done == $past(issue, 2)
  ) else $error("done is not exactly one cycle after issue");

  // Flag must agree with the registered result
  a_zero_flag: assert property (
    @(posedge clk) disable iff (reset) done |-> (zero == ~|result)
  ) else $error("zero flag does not match result");

  // Register file has a single write slot per edge
  a_load_exclusive: assert property (
    @(posedge clk) disable iff (reset) load |-> (!issue && !wb_en)
  ) else $error("load collides with issue or writeback");

  a_op_known: assert property (
    @(posedge clk) disable iff (reset) issue |-> !$isunknown(op)
  ) else $error("op has unknown bits on issue");

endmodule

// Load and the writeback enable both live at the core top level
bind alu_core_top alu_exec_asserts i_alu_exec_asserts (
  .clk    (clk),
  .reset  (reset),
  .issue  (issue),
  .op     (op),
  .load   (load),
  .wb_en  (wb_en),
  .done   (done),
  .result (result),
  .zero   (zero)
);

//--- sim/alu_core_tb.sv
// ALU core testbench

module alu_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 4;
  localparam int drain_cycles = 2;
  localparam int n_rand       = 40;
  // Reset, four table groups and the random stream
  localparam int n_drains     = 6;

  logic                       clk;
  logic                       reset;
  logic                       issue;
  logic [alu_pkg::sel_w-1:0]  op;
  logic [alu_pkg::addr_w-1:0] rd;
  logic [alu_pkg::addr_w-1:0] rs1;
  logic [alu_pkg::addr_w-1:0] rs2;
  logic                       load;
  logic [alu_pkg::addr_w-1:0] load_addr;
  logic [alu_pkg::word_w-1:0] load_data;
  logic [alu_pkg::addr_w-1:0] dbg_addr;
  logic [alu_pkg::word_w-1:0] dbg_data;
  logic                       done;
  logic [alu_pkg::word_w-1:0] result;
  logic                       zero;

  // Reference model state
  logic [alu_pkg::word_w-1:0] model_regs [alu_pkg::reg_n];
  logic [alu_pkg::word_w-1:0] exp_q [$];
  logic                       issued_now;
  logic                       issued_prev;

  // Stimulus table with one entry per row in each queue
  int                         row_group [$];
  bit                         row_load [$];
  logic [alu_pkg::sel_w-1:0]  row_op [$];
  logic [alu_pkg::addr_w-1:0] row_rd [$];
  logic [alu_pkg::addr_w-1:0] row_rs1 [$];
  logic [alu_pkg::addr_w-1:0] row_rs2 [$];
  logic [alu_pkg::word_w-1:0] row_val [$];

  int errors;
  int checks;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int cycle_count;
  int cycle_limit;

  alu_core_top i_alu_core_top (
    .clk       (clk),
    .reset     (reset),
    .issue     (issue),
    .op        (op),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .load      (load),
    .load_addr (load_addr),
    .load_data (load_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .done      (done),
    .result    (result),
    .zero      (zero)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Expected ALU output
  function automatic logic [alu_pkg::word_w-1:0] alu_model(
    input logic [alu_pkg::sel_w-1:0]  f,
    input logic [alu_pkg::word_w-1:0] a,
    input logic [alu_pkg::word_w-1:0] b
  );
    case (f)
      alu_pkg::op_add: return a + b;
      alu_pkg::op_sub: return a - b;
      alu_pkg::op_and: return a & b;
      alu_pkg::op_or:  return a | b;
      alu_pkg::op_slt: begin
        // Whole word shifted out
        if (b > 8'd7) return '0;
        return a << b;
      end
      alu_pkg::op_srt: begin
        if (b > 8'd7) return '0;
        return a >> b;
      end
      alu_pkg::op_not: return ~a;
      default:         return '0;
    endcase
  endfunction

  function automatic string group_name(input int g);
    case (g)
      1:       return "loads";
      2:       return "opcodes";
      3:       return "zero_flag";
      4:       return "forwarding";
      default: return "unknown";
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic add_load(input int g, input int addr, input int val);
    row_group.push_back(g);
    row_load.push_back(1'b1);
    row_op.push_back(alu_pkg::op_nop);
    row_rd.push_back(2'(addr));
    row_rs1.push_back(2'd0);
    row_rs2.push_back(2'd0);
    row_val.push_back(8'(val));
  endtask

  task automatic add_issue(input int g, input logic [alu_pkg::sel_w-1:0] f,
                           input int d, input int s1, input int s2);
    row_group.push_back(g);
    row_load.push_back(1'b0);
    row_op.push_back(f);
    row_rd.push_back(2'(d));
    row_rs1.push_back(2'(s1));
    row_rs2.push_back(2'(s2));
    row_val.push_back(8'd0);
  endtask

  task automatic build_table();
    add_load(1, 0, 'h11);
    add_load(1, 1, 'h22);
    add_load(1, 2, 'h33);
    add_load(1, 3, 'h44);
    add_load(1, 1, 'h5a);
    // Arithmetic wrap and borrow followed by logic ops
    add_load(2, 0, 'hf0);
    add_load(2, 1, 'h20);
    add_issue(2, alu_pkg::op_add, 2, 0, 1);
    add_issue(2, alu_pkg::op_sub, 3, 1, 0);
    add_issue(2, alu_pkg::op_and, 2, 0, 1);
    add_issue(2, alu_pkg::op_or, 3, 0, 1);
    // Shifts by 0, 8, 3 and 255
    add_load(2, 2, 'h00);
    add_load(2, 3, 'h08);
    add_issue(2, alu_pkg::op_slt, 1, 0, 2);
    add_issue(2, alu_pkg::op_srt, 1, 0, 2);
    add_issue(2, alu_pkg::op_srt, 1, 0, 3);
    add_issue(2, alu_pkg::op_slt, 1, 0, 3);
    add_load(2, 2, 'h03);
    add_issue(2, alu_pkg::op_slt, 1, 0, 2);
    add_issue(2, alu_pkg::op_srt, 1, 0, 2);
    add_issue(2, alu_pkg::op_not, 1, 0, 0);
    add_load(2, 3, 'hff);
    add_issue(2, alu_pkg::op_slt, 1, 0, 3);
    add_issue(2, alu_pkg::op_nop, 0, 1, 2);
    // Zero and nonzero results
    add_issue(3, alu_pkg::op_sub, 1, 0, 0);
    add_load(3, 2, 'h0f);
    add_issue(3, alu_pkg::op_and, 1, 0, 2);
    add_issue(3, alu_pkg::op_or, 1, 0, 2);
    add_issue(3, alu_pkg::op_add, 2, 3, 3);
    add_load(3, 1, 'h01);
    add_issue(3, alu_pkg::op_add, 1, 3, 1);
    // Dependent chain forwarding rs1, rs2 and both
    add_load(4, 0, 'h05);
    add_load(4, 1, 'h03);
    add_issue(4, alu_pkg::op_add, 2, 0, 1);
    add_issue(4, alu_pkg::op_add, 3, 2, 0);
    add_issue(4, alu_pkg::op_sub, 0, 3, 2);
    add_issue(4, alu_pkg::op_and, 1, 1, 0);
    add_issue(4, alu_pkg::op_add, 1, 1, 1);
    add_issue(4, alu_pkg::op_slt, 1, 1, 1);
    add_issue(4, alu_pkg::op_nop, 1, 1, 1);
    add_issue(4, alu_pkg::op_or, 2, 1, 1);
  endtask

  // Advance one clock, check completion, return inputs to idle
  task automatic next_cycle();
    logic                       exp_done;
    logic [alu_pkg::word_w-1:0] exp_res;
    @(posedge clk);
    #2;
    exp_done    = issued_prev;
    issued_prev = issued_now;
    issued_now  = 1'b0;
    check("done", 32'(exp_done), 32'(done));
    if (exp_done) begin
      exp_res = exp_q.pop_front();
      check("result", 32'(exp_res), 32'(result));
      check("zero", 32'(exp_res == '0), 32'(zero));
    end
    issue = 1'b0;
    load  = 1'b0;
  endtask

  task automatic drive_issue(input logic [alu_pkg::sel_w-1:0] f,
                             input logic [alu_pkg::addr_w-1:0] d,
                             input logic [alu_pkg::addr_w-1:0] s1,
                             input logic [alu_pkg::addr_w-1:0] s2);
    logic [alu_pkg::word_w-1:0] res;
    res = alu_model(f, model_regs[s1], model_regs[s2]);
    exp_q.push_back(res);
    if (f != alu_pkg::op_nop) begin
      model_regs[d] = res;
    end
    issue      = 1'b1;
    op         = f;
    rd         = d;
    rs1        = s1;
    rs2        = s2;
    issued_now = 1'b1;
  endtask

  task automatic drive_load(input logic [alu_pkg::addr_w-1:0] addr,
                            input logic [alu_pkg::word_w-1:0] val);
    load             = 1'b1;
    load_addr        = addr;
    load_data        = val;
    model_regs[addr] = val;
  endtask

  task automatic apply_row(input int i);
    next_cycle();
    if (row_load[i]) begin
      // Writeback of the previous issue owns this cycle
      if (issued_prev) begin
        next_cycle();
      end
      drive_load(row_rd[i], row_val[i]);
    end else begin
      drive_issue(row_op[i], row_rd[i], row_rs1[i], row_rs2[i]);
    end
  endtask

  task automatic check_regs();
    for (int i = 0; i < alu_pkg::reg_n; i++) begin
      dbg_addr = 2'(i);
      #1;
      check($sformatf("dbg_data[%0d]", i), 32'(model_regs[i]), 32'(dbg_data));
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s ok", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic end_group(input int g);
    repeat (drain_cycles) next_cycle();
    check_regs();
    finish_test(group_name(g));
  endtask

  initial begin
    void'($urandom(87968));
    reset        = 1'b1;
    issue        = 1'b0;
    op           = alu_pkg::op_nop;
    rd           = '0;
    rs1          = '0;
    rs2          = '0;
    load         = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    dbg_addr     = '0;
    issued_now   = 1'b0;
    issued_prev  = 1'b0;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;
    for (int i = 0; i < alu_pkg::reg_n; i++) begin
      model_regs[i] = '0;
    end
    build_table();
    // One cycle per row, random load and random issue, plus the drains
    // Load gaps after issues stay within the slack
    cycle_limit = reset_cycles + row_load.size() + alu_pkg::reg_n + n_rand
                + drain_cycles * n_drains + 20;

    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
    check("done", 32'd0, 32'(done));
    check("result", 32'd0, 32'(result));
    check("zero", 32'd1, 32'(zero));
    check_regs();
    repeat (drain_cycles) next_cycle();
    finish_test("reset");

    for (int i = 0; i < row_load.size(); i++) begin
      if (i > 0 && row_group[i] != row_group[i-1]) begin
        end_group(row_group[i-1]);
      end
      apply_row(i);
    end
    end_group(row_group[row_group.size()-1]);

    // Random register contents followed by an instruction every cycle
    for (int r = 0; r < alu_pkg::reg_n; r++) begin
      next_cycle();
      drive_load(2'(r), 8'($urandom));
    end
    for (int n = 0; n < n_rand; n++) begin
      next_cycle();
      drive_issue(3'($urandom), 2'($urandom), 2'($urandom), 2'($urandom));
    end
    repeat (drain_cycles) next_cycle();
    check_regs();
    finish_test("random");

    $display("Tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- alu_core.f
logic/alu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/alu_exec.sv
logic/alu_core_top.sv
sim/alu_core_asserts.sv
sim/alu_core_tb.sv

//--- Makefile
# Verilator flow for the ALU core

SIM_TOOL := verilator
TOP      := alu_core_tb
FILELIST := alu_core.f
OBJ_DIR  := obj_dir
FLAGS    := --timing --assert --timescale 1ns/100ps
PASS_MSG := === PASS ===

.PHONY: all lint sim clean

all: sim

# Static checks only
lint:
	$(SIM_TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, the pass line in the output decides the status
sim:
	$(SIM_TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
